//--- Bender.yml
package:
  name: buzzer

sources:
  # Packages first, then the player and the bus side
  - files:
      - common/buzzerPkg.sv
      - common/axiLitePkg.sv
      - player/noteMemory.sv
      - player/durationTimer.sv
      - player/toneGenerator.sv
      - player/noteSequencer.sv
      - source/axiLiteRegs.sv
      - source/buzzerTop.sv

  - target: simulation
    files:
      - sim/buzzerAsserts_asserts.sv
      - sim/buzzerTb.sv

//--- common/axiLitePkg.sv
package axiLitePkg;

    localparam int unsigned AddrWidth = 12;
    localparam int unsigned DataWidth = 32;

    // Manager to subordinate without write strobes
    typedef struct packed {
        logic [AddrWidth-1:0] awaddr;
        logic                 awvalid;
        logic [DataWidth-1:0] wdata;
        logic                 wvalid;
        logic                 bready;
        logic [AddrWidth-1:0] araddr;
        logic                 arvalid;
        logic                 rready;
    } axiReqT;

    // Subordinate to manager
    typedef struct packed {
        logic                 awready;
        logic                 wready;
        logic                 bvalid;
        logic [1:0]           bresp;
        logic                 arready;
        logic                 rvalid;
        logic [DataWidth-1:0] rdata;
        logic [1:0]           rresp;
    } axiRspT;

    // ------------------------------------------------------------------------
    // Response codes
    // ------------------------------------------------------------------------

    localparam logic [1:0] RespOkay   = 2'b00;
    localparam logic [1:0] RespSlvErr = 2'b10;

endpackage

//--- common/buzzerPkg.sv
package buzzerPkg;

    // ------------------------------------------------------------------------
    // Note table
    // ------------------------------------------------------------------------

    // One note per 32-bit word of the table
    typedef struct packed {
        // Clock cycles per PWM half-period where 0 marks a rest
        logic [15:0] divider;
        // Note length in duration ticks
        logic [15:0] duration;
    } noteT;

    // Index into the note table
    typedef logic [3:0] noteIdxT;

    // ------------------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------------------

    // Control register where bit 0 starts the song
    localparam logic [11:0] CtrlOffset = 12'h000;

    // Status register with busy in bit 0
    localparam logic [11:0] StatusOffset = 12'h004;

    // Number of notes in the song
    localparam logic [11:0] LengthOffset = 12'h008;

    // Entry i at NoteBase + 4*i
    localparam logic [11:0] NoteBase = 12'h100;

    // ------------------------------------------------------------------------
    // Player defaults
    // ------------------------------------------------------------------------

    localparam int unsigned DefaultNoteDepth = 16;

    // Clock cycles per duration tick
    localparam int unsigned DefaultTickCycles = 16;

endpackage

//--- player/durationTimer.sv
`timescale 1ns/100ps

module durationTimer #(
    parameter int unsigned TickCycles = buzzerPkg::DefaultTickCycles
) (
    input  logic        clk,
    input  logic        RSTn,
    input  logic        load,
    input  logic [15:0] duration,
    output logic        done
);

    localparam int unsigned PrescWidth = (TickCycles > 1) ? $clog2(TickCycles) : 1;

    logic [PrescWidth-1:0] prescCnt;
    logic [15:0]           ticksLeft;
    logic                  active;
    logic                  tick;

    // Last cycle of a tick
    assign tick = active && (prescCnt == PrescWidth'(TickCycles - 1));
    assign done = tick && (ticksLeft == 16'd1);

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            active    <= 1'b0;
            prescCnt  <= '0;
            ticksLeft <= '0;
        end else if (load) begin
            active    <= (duration != '0);
            prescCnt  <= '0;
            ticksLeft <= duration;
        end else if (active) begin
            prescCnt <= tick ? '0 : prescCnt + 1'b1;
            if (tick) begin
                ticksLeft <= ticksLeft - 16'd1;
            end
            if (done) begin
                active <= 1'b0;
            end
        end
    end

endmodule

//--- player/noteMemory.sv
`timescale 1ns/100ps

module noteMemory #(
    parameter int unsigned NoteDepth = buzzerPkg::DefaultNoteDepth
) (
    input  logic               clk,
    input  logic               wrEn,
    input  buzzerPkg::noteIdxT wrIdx,
    input  buzzerPkg::noteT    wrNote,
    input  buzzerPkg::noteIdxT rdIdx,
    output buzzerPkg::noteT    rdNote,
    input  buzzerPkg::noteIdxT busRdIdx,
    output buzzerPkg::noteT    busRdNote
);

    buzzerPkg::noteT mem [NoteDepth];

    // Host write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrIdx] <= wrNote;
        end
    end

    // ------------------------------------------------------------------------
    // Registered read ports
    // ------------------------------------------------------------------------

    // Player side
    always_ff @(posedge clk) begin
        rdNote <= mem[rdIdx];
    end

    // Bus readback side
    always_ff @(posedge clk) begin
        busRdNote <= mem[busRdIdx];
    end

endmodule

//--- player/noteSequencer.sv
`timescale 1ns/100ps

module noteSequencer (
    input  logic                                clk,
    input  logic                                RSTn,
    input  logic                                start,
    input  logic [$bits(buzzerPkg::noteIdxT):0] songLength,
    output buzzerPkg::noteIdxT                  rdIdx,
    input  buzzerPkg::noteT                     rdNote,
    output logic                                load,
    output logic [15:0]                         duration,
    input  logic                                done,
    output logic                                toneEn,
    output logic [15:0]                         divider,
    output logic                                busy
);

    localparam int unsigned IdxWidth = $bits(buzzerPkg::noteIdxT);

    typedef enum logic [1:0] {
        Idle,
        Fetch,
        Load,
        Play
    } stateT;

    stateT             state;
    stateT             stateNext;
    logic [IdxWidth:0] noteCnt;
    logic              lastNote;
    logic              noteEnd;
    buzzerPkg::noteT   curNote;

    assign lastNote = ((noteCnt + 1'b1) == songLength);

    // Zero-length notes skip Play and cost only fetch and load
    assign noteEnd = ((state == Load) && (rdNote.duration == '0)) ||
                     ((state == Play) && done);

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------

    always_comb begin
        stateNext = state;
        case (state)
            Idle: begin
                if (start) begin
                    stateNext = Fetch;
                end
            end
            Fetch: begin
                stateNext = Load;
            end
            Load, Play: begin
                if (noteEnd) begin
                    stateNext = lastNote ? Idle : Fetch;
                end else if (state == Load) begin
                    stateNext = Play;
                end
            end
            default: begin
                stateNext = Idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            state   <= Idle;
            noteCnt <= '0;
        end else begin
            state <= stateNext;
            if (state == Idle) begin
                noteCnt <= '0;
            end else if (noteEnd && !lastNote) begin
                noteCnt <= noteCnt + 1'b1;
            end
        end
    end

    // Note word arrives from memory during Load
    always_ff @(posedge clk) begin
        if (state == Load) begin
            curNote <= rdNote;
        end
    end

    assign rdIdx    = noteCnt[IdxWidth-1:0];
    assign load     = (state == Load);
    assign duration = rdNote.duration;
    assign divider  = curNote.divider;
    assign toneEn   = (state == Play) && (curNote.divider != '0);
    assign busy     = (state != Idle);

endmodule

//--- player/toneGenerator.sv
`timescale 1ns/100ps

module toneGenerator (
    input  logic        clk,
    input  logic        RSTn,
    input  logic        toneEn,
    input  logic [15:0] divider,
    output logic        pwm
);

    logic [15:0] halfCnt;
    logic        level;

    // ------------------------------------------------------------------------
    // Half-period counter
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            halfCnt <= '0;
            level   <= 1'b0;
        end else if (!toneEn) begin
            // Next note starts from a low half-period
            halfCnt <= '0;
            level   <= 1'b0;
        end else if (halfCnt == divider - 16'd1) begin
            halfCnt <= '0;
            level   <= ~level;
        end else begin
            halfCnt <= halfCnt + 16'd1;
        end
    end

    // Pin drops at once when the tone stops
    assign pwm = toneEn & level;

endmodule

//--- sim/buzzerAsserts_asserts.sv
`timescale 1ns/100ps

module buzzerAsserts (
    input logic               clk,
    input logic               RSTn,
    input axiLitePkg::axiReqT axiReq,
    input axiLitePkg::axiRspT axiRsp,
    input logic               busy,
    input logic               pwm
);

    // Responses hold until the manager takes them
    assert property (@(posedge clk) disable iff (!RSTn)
        axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid)
        else $error("bvalid dropped before bready");

    assert property (@(posedge clk) disable iff (!RSTn)
        axiRsp.rvalid && !axiReq.rready |=> axiRsp.rvalid)
        else $error("rvalid dropped before rready");

    assert property (@(posedge clk) disable iff (!RSTn)
        axiRsp.rvalid && !axiReq.rready |=> $stable(axiRsp.rdata) && $stable(axiRsp.rresp))
        else $error("read data changed while rvalid waited");

    // Pin is quiet when idle
    assert property (@(posedge clk) disable iff (!RSTn) !busy |-> !pwm)
        else $error("pwm high while the player is idle");

endmodule

bind buzzerTop buzzerAsserts i_buzzerAsserts (
    .clk    (clk),
    .RSTn   (RSTn),
    .axiReq (axiReq),
    .axiRsp (axiRsp),
    .busy   (busy),
    .pwm    (pwm)
);

//--- sim/buzzerTb.sv
`timescale 1ns/100ps

module buzzerTb;

    localparam int unsigned NoteDepth   = buzzerPkg::DefaultNoteDepth;
    localparam int unsigned TickCycles  = buzzerPkg::DefaultTickCycles;
    localparam int          Timeout     = 50;
    localparam int          SongTimeout = 10000;

    logic               clk;
    logic               RSTn;
    axiLitePkg::axiReqT axiReq;
    axiLitePkg::axiRspT axiRsp;
    logic               pwm;
    logic               dutBusy;

    integer             seed;
    int                 errorCount;
    int                 timeoutCount;

    // Reference model of the register file
    buzzerPkg::noteT    noteModel [NoteDepth];
    logic [31:0]        lengthModel;

    buzzerTop #(
        .NoteDepth  (NoteDepth),
        .TickCycles (TickCycles)
    ) i_buzzerTop (
        .clk    (clk),
        .RSTn   (RSTn),
        .axiReq (axiReq),
        .axiRsp (axiRsp),
        .pwm    (pwm)
    );

    assign dutBusy = i_buzzerTop.busy;

    always #4 clk = ~clk;

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------

    task automatic compareNote(input string name, input buzzerPkg::noteT got,
                               input buzzerPkg::noteT exp);
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compareResp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compareWord(input string name, input logic [axiLitePkg::DataWidth-1:0] got,
                               input logic [axiLitePkg::DataWidth-1:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compareCycles(input string name, input int got, input int exp);
        if (got != exp) begin
            errorCount++;
            $display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic reportTimeout(input string what);
        timeoutCount++;
        $display("Timeout at %0t: the DUT never raised %s", $time, what);
    endtask

    // ------------------------------------------------------------------------
    // Address and stimulus helpers
    // ------------------------------------------------------------------------

    function automatic logic [11:0] noteAddr(input int idx);
        return buzzerPkg::NoteBase + 12'(4 * idx);
    endfunction

    function automatic logic isMappedAddr(input logic [11:0] addr);
        return (addr == buzzerPkg::CtrlOffset) || (addr == buzzerPkg::StatusOffset) ||
               (addr == buzzerPkg::LengthOffset) ||
               ((addr >= buzzerPkg::NoteBase) && (addr < noteAddr(NoteDepth)) &&
                (addr[1:0] == 2'b00));
    endfunction

    // Short notes so a song stays a few hundred cycles long
    function automatic buzzerPkg::noteT randomNote(input int minDuration);
        buzzerPkg::noteT note;
        if ($unsigned($random(seed)) % 4 == 0) begin
            note.divider = '0;
        end else begin
            note.divider = 16'(1 + $unsigned($random(seed)) % 12);
        end
        note.duration = 16'(minDuration + $unsigned($random(seed)) % (5 - minDuration));
        return note;
    endfunction

    // ------------------------------------------------------------------------
    // AXI4-Lite driver tasks start and end 1 ns after a rising edge
    // ------------------------------------------------------------------------

    task automatic axiWrite(input logic [11:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
        int waitCnt;
        int holdOff;
        axiReq.awaddr  = addr;
        axiReq.wdata   = data;
        axiReq.awvalid = 1'b1;
        axiReq.wvalid  = 1'b1;
        waitCnt = 0;
        @(negedge clk);
        while (!(axiRsp.awready && axiRsp.wready) && waitCnt < Timeout) begin
            waitCnt++;
            @(negedge clk);
        end
        if (!(axiRsp.awready && axiRsp.wready)) begin
            reportTimeout("awready and wready");
        end
        @(posedge clk);
        #1;
        axiReq.awvalid = 1'b0;
        axiReq.wvalid  = 1'b0;
        // Random back-pressure on the write response channel
        holdOff = $unsigned($random(seed)) % 4;
        repeat (holdOff) begin
            @(posedge clk);
            #1;
        end
        axiReq.bready  = 1'b1;
        waitCnt = 0;
        @(negedge clk);
        while (!axiRsp.bvalid && waitCnt < Timeout) begin
            waitCnt++;
            @(negedge clk);
        end
        if (!axiRsp.bvalid) begin
            reportTimeout("bvalid");
        end
        resp = axiRsp.bresp;
        @(posedge clk);
        #1;
        axiReq.bready = 1'b0;
    endtask

    task automatic axiRead(input logic [11:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
        int waitCnt;
        int holdOff;
        axiReq.araddr  = addr;
        axiReq.arvalid = 1'b1;
        axiReq.rready  = 1'b0;
        waitCnt = 0;
        @(negedge clk);
        while (!axiRsp.arready && waitCnt < Timeout) begin
            waitCnt++;
            @(negedge clk);
        end
        if (!axiRsp.arready) begin
            reportTimeout("arready");
        end
        @(posedge clk);
        #1;
        axiReq.arvalid = 1'b0;
        // Random back-pressure on the read data channel
        holdOff = $unsigned($random(seed)) % 4;
        repeat (holdOff) begin
            @(posedge clk);
            #1;
        end
        axiReq.rready = 1'b1;
        waitCnt = 0;
        @(negedge clk);
        while (!axiRsp.rvalid && waitCnt < Timeout) begin
            waitCnt++;
            @(negedge clk);
        end
        if (!axiRsp.rvalid) begin
            reportTimeout("rvalid");
        end
        data = axiRsp.rdata;
        resp = axiRsp.rresp;
        @(posedge clk);
        #1;
        axiReq.rready = 1'b0;
    endtask

    task automatic writeExpect(input logic [11:0] addr, input logic [31:0] data,
                               input logic [1:0] expResp, input string name);
        logic [1:0] resp;
        axiWrite(addr, data, resp);
        compareResp({name, " bresp"}, resp, expResp);
    endtask

    task automatic readExpect(input logic [11:0] addr, input logic [31:0] expData,
                              input logic [1:0] expResp, input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axiRead(addr, data, resp);
        compareWord({name, " rdata"}, data, expData);
        compareResp({name, " rresp"}, resp, expResp);
    endtask

    // Whole table and LENGTH against the model
    task automatic checkTable();
        logic [31:0] data;
        logic [1:0]  resp;
        for (int i = 0; i < NoteDepth; i++) begin
            axiRead(noteAddr(i), data, resp);
            compareNote($sformatf("note[%0d]", i), buzzerPkg::noteT'(data), noteModel[i]);
            compareResp($sformatf("note[%0d] rresp", i), resp, axiLitePkg::RespOkay);
        end
        readExpect(buzzerPkg::LengthOffset, lengthModel, axiLitePkg::RespOkay, "LENGTH");
    endtask

    // ------------------------------------------------------------------------
    // Song monitor
    // ------------------------------------------------------------------------

    task automatic monitorSong(input int numNotes);
        int              waitCnt;
        int              busyCycles;
        int              expCycles;
        int              playLen;
        int              lastEdge;
        int              edges;
        logic            prevPwm;
        buzzerPkg::noteT note;
        busyCycles = 0;
        expCycles  = 0;
        waitCnt    = 0;
        @(negedge clk);
        while (!axiRsp.awready && waitCnt < Timeout) begin
            waitCnt++;
            @(negedge clk);
        end
        if (!axiRsp.awready) begin
            reportTimeout("awready for the start write");
        end
        for (int k = 0; k < numNotes; k++) begin
            note     = noteModel[k];
            playLen  = note.duration * TickCycles;
            expCycles += playLen + 2;
            lastEdge = 0;
            edges    = 0;
            prevPwm  = 1'b0;
            // Cycles -2 and -1 are fetch and load
            for (int j = -2; j < playLen; j++) begin
                @(negedge clk);
                if (dutBusy) begin
                    busyCycles++;
                end
                if (j <= 0 || note.divider == '0) begin
                    compareBit($sformatf("pwm note %0d", k), pwm, 1'b0);
                end else if (pwm !== prevPwm) begin
                    compareCycles($sformatf("pwm interval note %0d", k), j - lastEdge,
                                  int'(note.divider));
                    lastEdge = j;
                    edges++;
                end
                prevPwm = pwm;
            end
            if (note.divider != '0) begin
                compareCycles($sformatf("pwm edges note %0d", k), edges,
                              (playLen - 1) / int'(note.divider));
            end
        end
        waitCnt = 0;
        @(negedge clk);
        while (dutBusy && waitCnt < SongTimeout) begin
            busyCycles++;
            waitCnt++;
            @(negedge clk);
        end
        if (dutBusy) begin
            $display("Timeout at %0t: busy never fell after the song", $time);
            timeoutCount++;
        end
        compareCycles("busy cycles", busyCycles, expCycles);
    endtask

    // Table and LENGTH must be frozen while playing
    task automatic busyWrites();
        int          idx;
        logic [31:0] data;
        idx  = $unsigned($random(seed)) % NoteDepth;
        data = $random(seed);
        writeExpect(noteAddr(idx), data, axiLitePkg::RespSlvErr, "busy note write");
        writeExpect(buzzerPkg::LengthOffset, 32'd3, axiLitePkg::RespSlvErr, "busy LENGTH write");
        writeExpect(buzzerPkg::CtrlOffset, 32'd1, axiLitePkg::RespOkay, "busy CTRL write");
        readExpect(buzzerPkg::StatusOffset, 32'd1, axiLitePkg::RespOkay, "busy STATUS");
    endtask

    task automatic playSong(input int numNotes, input int minDuration, input bit whileBusy);
        for (int i = 0; i < numNotes; i++) begin
            noteModel[i] = randomNote(minDuration);
            writeExpect(noteAddr(i), noteModel[i], axiLitePkg::RespOkay, "song note write");
        end
        lengthModel = numNotes;
        writeExpect(buzzerPkg::LengthOffset, lengthModel, axiLitePkg::RespOkay, "LENGTH write");
        fork
            monitorSong(numNotes);
            begin
                writeExpect(buzzerPkg::CtrlOffset, 32'd1, axiLitePkg::RespOkay, "start write");
                if (whileBusy) begin
                    busyWrites();
                end
            end
        join
        @(posedge clk);
        #1;
        checkTable();
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        logic [11:0] addr;
        seed         = 32'hdf53;
        errorCount   = 0;
        timeoutCount = 0;
        clk          = 1'b0;
        RSTn         = 1'b0;
        axiReq       = '0;
        repeat (2) @(posedge clk);
        #1;
        RSTn = 1'b1;
        @(negedge clk);
        compareBit("bvalid after reset", axiRsp.bvalid, 1'b0);
        compareBit("rvalid after reset", axiRsp.rvalid, 1'b0);
        compareBit("busy after reset", dutBusy, 1'b0);
        compareBit("pwm after reset", pwm, 1'b0);
        @(posedge clk);
        #1;

        // Random table and LENGTH followed by readback
        for (int i = 0; i < NoteDepth; i++) begin
            noteModel[i] = buzzerPkg::noteT'($random(seed));
            writeExpect(noteAddr(i), noteModel[i], axiLitePkg::RespOkay, "note write");
        end
        lengthModel = 1 + $unsigned($random(seed)) % NoteDepth;
        writeExpect(buzzerPkg::LengthOffset, lengthModel, axiLitePkg::RespOkay, "LENGTH write");
        checkTable();
        readExpect(buzzerPkg::CtrlOffset, 32'd0, axiLitePkg::RespOkay, "CTRL");
        readExpect(buzzerPkg::StatusOffset, 32'd0, axiLitePkg::RespOkay, "idle STATUS");

        // Unmapped addresses and STATUS write
        for (int i = 0; i < 8; i++) begin
            addr = $random(seed);
            if (isMappedAddr(addr)) begin
                addr = addr + 12'h200;
            end
            writeExpect(addr, $random(seed), axiLitePkg::RespSlvErr, "unmapped write");
            readExpect(addr, 32'd0, axiLitePkg::RespSlvErr, "unmapped read");
        end
        writeExpect(buzzerPkg::StatusOffset, 32'd1, axiLitePkg::RespSlvErr, "STATUS write");
        checkTable();

        // Two songs where the second also writes while busy
        playSong(4 + $unsigned($random(seed)) % 6, 0, 1'b0);
        playSong(4 + $unsigned($random(seed)) % 4, 1, 1'b1);

        // Start with LENGTH 0 must not play
        lengthModel = 0;
        writeExpect(buzzerPkg::LengthOffset, lengthModel, axiLitePkg::RespOkay, "LENGTH zero");
        writeExpect(buzzerPkg::CtrlOffset, 32'd1, axiLitePkg::RespOkay, "empty start");
        repeat (4) begin
            @(negedge clk);
            compareBit("busy after empty start", dutBusy, 1'b0);
        end
        @(posedge clk);
        #1;
        readExpect(buzzerPkg::StatusOffset, 32'd0, axiLitePkg::RespOkay, "empty STATUS");

        $display("Checks done: %0d errors, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- source/axiLiteRegs.sv
`timescale 1ns/100ps

module axiLiteRegs #(
    parameter int unsigned NoteDepth = buzzerPkg::DefaultNoteDepth
) (
    input  logic                                clk,
    input  logic                                RSTn,
    input  axiLitePkg::axiReqT                  axiReq,
    output axiLitePkg::axiRspT                  axiRsp,
    input  logic                                busy,
    output logic                                start,
    output logic [$bits(buzzerPkg::noteIdxT):0] songLength,
    output logic                                wrEn,
    output buzzerPkg::noteIdxT                  wrIdx,
    output buzzerPkg::noteT                     wrNote,
    output buzzerPkg::noteIdxT                  busRdIdx,
    input  buzzerPkg::noteT                     busRdNote
);

    localparam int unsigned IdxWidth = $bits(buzzerPkg::noteIdxT);
    localparam int unsigned DataWidth = axiLitePkg::DataWidth;
    localparam int unsigned NoteEnd = buzzerPkg::NoteBase + 4 * NoteDepth;

    logic                  wrAccept;
    logic                  wrCtrl;
    logic                  wrLength;
    logic                  wrNoteHit;
    logic                  wrOkay;
    logic                  bvalid;
    logic [1:0]            bresp;
    logic [IdxWidth:0]     lengthQ;
    logic                  rdAccept;
    logic                  rdNoteHit;
    logic [DataWidth-1:0]  regRdata;
    logic [1:0]            regRresp;
    logic                  rvalid;
    logic                  rdFirst;
    logic                  rdIsNote;
    logic [DataWidth-1:0]  rdRegData;
    logic [1:0]            rresp;
    buzzerPkg::noteT       noteHold;
    logic [DataWidth-1:0]  rdata;

    // Word-aligned address inside the populated part of the note table
    function automatic logic isNoteAddr(input logic [axiLitePkg::AddrWidth-1:0] addr);
        return (addr >= buzzerPkg::NoteBase) && (addr < NoteEnd) && (addr[1:0] == 2'b00);
    endfunction

    // ------------------------------------------------------------------------
    // Write channel
    // ------------------------------------------------------------------------

    assign wrAccept  = axiReq.awvalid & axiReq.wvalid & ~bvalid;
    assign wrCtrl    = (axiReq.awaddr == buzzerPkg::CtrlOffset);
    assign wrLength  = (axiReq.awaddr == buzzerPkg::LengthOffset);
    assign wrNoteHit = isNoteAddr(axiReq.awaddr);

    // Table and length are frozen while a song plays
    assign wrOkay = wrCtrl | ((wrLength | wrNoteHit) & ~busy);

    assign wrEn   = wrAccept & wrNoteHit & ~busy;
    assign wrIdx  = axiReq.awaddr[2 +: IdxWidth];
    assign wrNote = buzzerPkg::noteT'(axiReq.wdata);

    assign start = wrAccept & wrCtrl & axiReq.wdata[0] & (lengthQ != '0) & ~busy;
    assign songLength = lengthQ;

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            bvalid  <= 1'b0;
            lengthQ <= '0;
        end else begin
            if (wrAccept) begin
                bvalid <= 1'b1;
            end else if (axiReq.bready) begin
                bvalid <= 1'b0;
            end
            if (wrAccept && wrLength && !busy) begin
                lengthQ <= axiReq.wdata[IdxWidth:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrAccept) begin
            bresp <= wrOkay ? axiLitePkg::RespOkay : axiLitePkg::RespSlvErr;
        end
    end

    // ------------------------------------------------------------------------
    // Read channel
    // ------------------------------------------------------------------------

    assign rdAccept  = axiReq.arvalid & ~rvalid;
    assign rdNoteHit = isNoteAddr(axiReq.araddr);

    // Memory answers one cycle later, in the first rvalid cycle
    assign busRdIdx = axiReq.araddr[2 +: IdxWidth];

    always_comb begin
        regRdata = '0;
        regRresp = axiLitePkg::RespOkay;
        if (axiReq.araddr == buzzerPkg::StatusOffset) begin
            regRdata = DataWidth'(busy);
        end else if (axiReq.araddr == buzzerPkg::LengthOffset) begin
            regRdata = DataWidth'(lengthQ);
        end else if (axiReq.araddr != buzzerPkg::CtrlOffset && !rdNoteHit) begin
            regRresp = axiLitePkg::RespSlvErr;
        end
    end

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            rvalid   <= 1'b0;
            rdFirst  <= 1'b0;
            rdIsNote <= 1'b0;
        end else begin
            rdFirst <= rdAccept;
            if (rdAccept) begin
                rvalid   <= 1'b1;
                rdIsNote <= rdNoteHit;
            end else if (axiReq.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdAccept) begin
            rdRegData <= regRdata;
            rresp     <= regRresp;
        end
        // Keep the note word in case rready is held off
        if (rdFirst) begin
            noteHold <= busRdNote;
        end
    end

    always_comb begin
        if (!rdIsNote) begin
            rdata = rdRegData;
        end else if (rdFirst) begin
            rdata = DataWidth'(busRdNote);
        end else begin
            rdata = DataWidth'(noteHold);
        end
    end

    always_comb begin
        axiRsp.awready = wrAccept;
        axiRsp.wready  = wrAccept;
        axiRsp.bvalid  = bvalid;
        axiRsp.bresp   = bresp;
        axiRsp.arready = rdAccept;
        axiRsp.rvalid  = rvalid;
        axiRsp.rdata   = rdata;
        axiRsp.rresp   = rresp;
    end

endmodule

//--- source/buzzerTop.sv
`timescale 1ns/100ps

module buzzerTop #(
    parameter int unsigned NoteDepth  = buzzerPkg::DefaultNoteDepth,
    parameter int unsigned TickCycles = buzzerPkg::DefaultTickCycles
) (
    input  logic               clk,
    input  logic               RSTn,
    input  axiLitePkg::axiReqT axiReq,
    output axiLitePkg::axiRspT axiRsp,
    output logic               pwm
);

    logic                                 start;
    logic                                 busy;
    logic [$bits(buzzerPkg::noteIdxT):0]  songLength;
    logic                                 wrEn;
    buzzerPkg::noteIdxT                   wrIdx;
    buzzerPkg::noteT                      wrNote;
    buzzerPkg::noteIdxT                   busRdIdx;
    buzzerPkg::noteT                      busRdNote;
    buzzerPkg::noteIdxT                   rdIdx;
    buzzerPkg::noteT                      rdNote;
    logic                                 load;
    logic [15:0]                          duration;
    logic                                 done;
    logic                                 toneEn;
    logic [15:0]                          divider;

    // ------------------------------------------------------------------------
    // Host side
    // ------------------------------------------------------------------------

    axiLiteRegs #(.NoteDepth(NoteDepth)) i_axiLiteRegs (
        .clk        (clk),
        .RSTn       (RSTn),
        .axiReq     (axiReq),
        .axiRsp     (axiRsp),
        .busy       (busy),
        .start      (start),
        .songLength (songLength),
        .wrEn       (wrEn),
        .wrIdx      (wrIdx),
        .wrNote     (wrNote),
        .busRdIdx   (busRdIdx),
        .busRdNote  (busRdNote)
    );

    noteMemory #(.NoteDepth(NoteDepth)) i_noteMemory (
        .clk       (clk),
        .wrEn      (wrEn),
        .wrIdx     (wrIdx),
        .wrNote    (wrNote),
        .rdIdx     (rdIdx),
        .rdNote    (rdNote),
        .busRdIdx  (busRdIdx),
        .busRdNote (busRdNote)
    );

    // ------------------------------------------------------------------------
    // Player
    // ------------------------------------------------------------------------

    noteSequencer i_noteSequencer (
        .clk        (clk),
        .RSTn       (RSTn),
        .start      (start),
        .songLength (songLength),
        .rdIdx      (rdIdx),
        .rdNote     (rdNote),
        .load       (load),
        .duration   (duration),
        .done       (done),
        .toneEn     (toneEn),
        .divider    (divider),
        .busy       (busy)
    );

    durationTimer #(.TickCycles(TickCycles)) i_durationTimer (
        .clk      (clk),
        .RSTn     (RSTn),
        .load     (load),
        .duration (duration),
        .done     (done)
    );

    toneGenerator i_toneGenerator (
        .clk     (clk),
        .RSTn    (RSTn),
        .toneEn  (toneEn),
        .divider (divider),
        .pwm     (pwm)
    );

endmodule

//--- tb.f
common/buzzerPkg.sv
common/axiLitePkg.sv
player/noteMemory.sv
player/durationTimer.sv
player/toneGenerator.sv
player/noteSequencer.sv
source/axiLiteRegs.sv
source/buzzerTop.sv
sim/buzzerAsserts_asserts.sv
sim/buzzerTb.sv
